// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // address and instruction width
    localparam int XLEN = 32;

    // byte step between two sequential instructions
    localparam logic [XLEN-1:0] INST_BYTES = 32'd4;

    // memory response / tag width, zero means "not accepted"
    localparam int MEM_TAG_W = 4;

    //////////////////////////////////////////////////
    // memory block layout
    //////////////////////////////////////////////////

    localparam int BLOCK_W = 64;       // one memory block = one cache line

    // byte offset bits inside a block
    localparam int BLOCK_OFS_W = 3;

    // address bit that picks the upper or lower word of a block
    localparam int WORD_SEL_BIT = 2;

    //////////////////////////////////////////////////
    // memory command codes
    //////////////////////////////////////////////////

    // idle bus, nothing requested
    localparam logic [1:0] BUS_NONE = 2'h0;

    // block read, tag returned on mem2proc_response
    localparam logic [1:0] BUS_LOAD = 2'h1;

    // encodings follow the tagged memory model
    // 2'h2 (store) is not driven by the fetch front end
    // 2'h3 unused

    // response timing summary
    //   cycle n   : command + addr held, response != 0 accepts it
    //   cycle n+k : mem2proc_tag == accepted response, data valid
    //   k varies, one outstanding load per requester

endpackage

// ==== common/bp_if.sv ====
`timescale 1ns/1ns

interface bp_if;

    // lookup side, answered combinationally
    logic [fetch_pkg::XLEN-1:0] lookup_pc;   // pc being fetched
    logic                       pred_taken;  // btb hit with counter >= 2
    logic [fetch_pkg::XLEN-1:0] pred_pc;     // stored target of the entry

    // update side, one-cycle strobe per resolved branch
    logic                       upd_valid;
    logic [fetch_pkg::XLEN-1:0] upd_pc;
    logic                       upd_taken;
    logic [fetch_pkg::XLEN-1:0] upd_target;

    // fetch stage view
    modport fetch (
        output lookup_pc, upd_valid, upd_pc, upd_taken, upd_target,
        input  pred_taken, pred_pc
    );

    // predictor view
    modport predictor (
        input  lookup_pc, upd_valid, upd_pc, upd_taken, upd_target,
        output pred_taken, pred_pc
    );

endinterface

// ==== if_id_stage/branch_predictor.sv ====
`timescale 1ns/1ns

module branch_predictor #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic  clock,
    input  logic  reset,
    bp_if.predictor bp
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = fetch_pkg::XLEN - IDX_W - 2;   // pc bits above the index

    // table storage
    logic [BTB_ENTRIES-1:0]     btb_valid;
    logic [TAG_W-1:0]           btb_tag    [BTB_ENTRIES];
    logic [fetch_pkg::XLEN-1:0] btb_target [BTB_ENTRIES];
    logic [1:0]                 btb_ctr    [BTB_ENTRIES];  // 2-bit saturating

    // lookup fields
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             rd_hit;

    // update fields
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_hit;
    logic [1:0]       wr_ctr;                 // counter after this update
    logic             wr_entry;               // tag/target get written

    //////////////////////////////////////////////////
    // lookup, combinational
    //////////////////////////////////////////////////

    assign rd_idx = bp.lookup_pc[IDX_W+1:2];           // bits 1:0 always zero
    assign rd_tag = bp.lookup_pc[fetch_pkg::XLEN-1:IDX_W+2];
    assign rd_hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);

    assign bp.pred_taken = rd_hit & btb_ctr[rd_idx][1];  // weakly/strongly taken
    assign bp.pred_pc    = btb_target[rd_idx];

    //////////////////////////////////////////////////
    // update
    //////////////////////////////////////////////////

    assign wr_idx = bp.upd_pc[IDX_W+1:2];
    assign wr_tag = bp.upd_pc[fetch_pkg::XLEN-1:IDX_W+2];
    assign wr_hit = btb_valid[wr_idx] && (btb_tag[wr_idx] == wr_tag);

    always_comb begin
        wr_ctr = btb_ctr[wr_idx];
        if (!wr_hit) begin
            wr_ctr = 2'd2;                    // fresh entry, weakly taken
        end else if (bp.upd_taken) begin
            wr_ctr = (btb_ctr[wr_idx] == 2'd3) ? 2'd3 : btb_ctr[wr_idx] + 2'd1;
        end else begin
            wr_ctr = (btb_ctr[wr_idx] == 2'd0) ? 2'd0 : btb_ctr[wr_idx] - 2'd1;
        end
    end

    // not-taken miss leaves the table alone
    assign wr_entry = bp.upd_valid & (wr_hit | bp.upd_taken);

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (wr_entry) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_entry) begin
            btb_ctr[wr_idx] <= wr_ctr;
            if (bp.upd_taken) begin
                btb_tag[wr_idx]    <= wr_tag;
                btb_target[wr_idx] <= bp.upd_target;   // latest target wins
            end
        end
    end

endmodule

// ==== if_id_stage/if_id_stage.sv ====
`timescale 1ns/1ns

module if_id_stage #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic                       clock,
    input  logic                       reset,
    // stall levels
    input  logic                       rob_full,
    input  logic [3:0]                 rs_full,
    // resolved branch
    input  logic                       result_valid,
    input  logic [fetch_pkg::XLEN-1:0] result_pc,
    input  logic                       result_cond_branch,
    input  logic                       result_uncond_branch,
    input  logic                       result_taken,
    input  logic [fetch_pkg::XLEN-1:0] result_target_pc,
    input  logic                       result_mis_pred,
    // icache
    input  logic [fetch_pkg::XLEN-1:0] icache_data,
    input  logic                       icache_valid,
    output logic [fetch_pkg::XLEN-1:0] icache_addr,
    // fetch packet
    output logic                       id_valid,
    output logic [fetch_pkg::XLEN-1:0] id_pc,
    output logic [fetch_pkg::XLEN-1:0] id_inst,
    output logic                       id_pred_taken,
    output logic [fetch_pkg::XLEN-1:0] id_pred_pc
);

    logic [fetch_pkg::XLEN-1:0] pc;
    logic [fetch_pkg::XLEN-1:0] pc_next;
    logic [fetch_pkg::XLEN-1:0] pred_next;     // where fetch goes if this packet is taken
    logic [fetch_pkg::XLEN-1:0] redirect_pc;
    logic                       stall;
    logic                       redirect;
    logic                       fetch_fire;

    bp_if bp ();

    //////////////////////////////////////////////////
    // stall / flush decisions
    //////////////////////////////////////////////////

    assign stall      = rob_full | (|rs_full);           // any backend queue full
    assign redirect   = result_valid & result_mis_pred;  // flush wins over everything
    assign fetch_fire = icache_valid & ~stall & ~redirect;

    assign redirect_pc = result_taken ? result_target_pc
                                      : result_pc + fetch_pkg::INST_BYTES;

    // predicted successor of the pc now being fetched
    assign pred_next = bp.pred_taken ? bp.pred_pc : pc + fetch_pkg::INST_BYTES;

    always_comb begin
        pc_next = pc;                      // hold on stall or miss
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (fetch_fire) begin
            pc_next = pred_next;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign icache_addr = pc;

    //////////////////////////////////////////////////
    // fetch packet register
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= fetch_fire;        // drops on stall, miss or redirect
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_fire) begin
            id_pc         <= pc;
            id_inst       <= icache_data;
            id_pred_taken <= bp.pred_taken;
            id_pred_pc    <= pred_next;    // prediction actually used
        end
    end

    //////////////////////////////////////////////////
    // predictor lookup and training
    //////////////////////////////////////////////////

    assign bp.lookup_pc  = pc;
    // only real branches train the btb
    assign bp.upd_valid  = result_valid & (result_cond_branch | result_uncond_branch);
    assign bp.upd_pc     = result_pc;
    assign bp.upd_taken  = result_taken;
    assign bp.upd_target = result_target_pc;

    branch_predictor #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) branch_predictor_0 (
        .clock (clock),
        .reset (reset),
        .bp    (bp.predictor)
    );

endmodule

// ==== icache/icache.sv ====
`timescale 1ns/1ns

module icache #(
    parameter int ICACHE_LINES = 32
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [fetch_pkg::XLEN-1:0]      icache_addr,
    input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,
    input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag,
    input  logic [fetch_pkg::BLOCK_W-1:0]   mem2proc_data,
    output logic [fetch_pkg::XLEN-1:0]      icache_data,
    output logic                            icache_valid,
    output logic [1:0]                      proc2mem_command,
    output logic [fetch_pkg::XLEN-1:0]      proc2mem_addr
);

    localparam int OFS   = fetch_pkg::BLOCK_OFS_W;
    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = fetch_pkg::XLEN - IDX_W - OFS;

    // miss fsm states
    localparam logic [1:0] ST_IDLE = 2'd0;   // serving hits, watching for a miss
    localparam logic [1:0] ST_REQ  = 2'd1;   // BUS_LOAD held until accepted
    localparam logic [1:0] ST_WAIT = 2'd2;   // waiting for the pending tag

    logic [ICACHE_LINES-1:0]       line_valid;
    logic [TAG_W-1:0]              line_tag  [ICACHE_LINES];
    logic [fetch_pkg::BLOCK_W-1:0] line_data [ICACHE_LINES];

    logic [IDX_W-1:0]                rd_idx;
    logic [TAG_W-1:0]                rd_tag;
    logic [fetch_pkg::BLOCK_W-1:0]   rd_block;
    logic [1:0]                      state;
    logic [fetch_pkg::MEM_TAG_W-1:0] pending_tag;
    logic [fetch_pkg::XLEN-1:0]      miss_addr;   // block aligned, fixed for the whole miss
    logic                            fill;

    //////////////////////////////////////////////////
    // hit path, combinational
    //////////////////////////////////////////////////

    assign rd_idx   = icache_addr[IDX_W+OFS-1:OFS];
    assign rd_tag   = icache_addr[fetch_pkg::XLEN-1:IDX_W+OFS];
    assign rd_block = line_data[rd_idx];

    assign icache_valid = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
    assign icache_data  = icache_addr[fetch_pkg::WORD_SEL_BIT] ? rd_block[63:32]
                                                               : rd_block[31:0];

    //////////////////////////////////////////////////
    // single outstanding miss
    //////////////////////////////////////////////////

    assign fill = (state == ST_WAIT) && (mem2proc_tag == pending_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ST_IDLE;
            pending_tag <= '0;
        end else begin
            case (state)
                ST_IDLE: if (!icache_valid) state <= ST_REQ;
                ST_REQ: begin
                    if (mem2proc_response != '0) begin
                        pending_tag <= mem2proc_response;   // tag to match later
                        state       <= ST_WAIT;
                    end
                end
                ST_WAIT: if (fill) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // latch the missing block address once; later pc changes do not move it
    always_ff @(posedge clock) begin
        if (state == ST_IDLE && !icache_valid) begin
            miss_addr <= {icache_addr[fetch_pkg::XLEN-1:OFS], {OFS{1'b0}}};
        end
    end

    assign proc2mem_command = (state == ST_REQ) ? fetch_pkg::BUS_LOAD : fetch_pkg::BUS_NONE;
    assign proc2mem_addr    = miss_addr;

    // line fill, visible the cycle after the tag matches
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill) begin
            line_valid[miss_addr[IDX_W+OFS-1:OFS]] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            line_tag[miss_addr[IDX_W+OFS-1:OFS]]  <= miss_addr[fetch_pkg::XLEN-1:IDX_W+OFS];
            line_data[miss_addr[IDX_W+OFS-1:OFS]] <= mem2proc_data;
        end
    end

endmodule

// ==== verilog/processor.sv ====
`timescale 1ns/1ns

module processor #(
    parameter int ICACHE_LINES = 32,   // direct-mapped lines
    parameter int BTB_ENTRIES  = 16    // predictor entries
) (
    input  logic                           clock,
    input  logic                           reset,
    // tagged memory bus
    input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,  // accept tag for current cmd
    input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag,       // tag of returning data
    input  logic [fetch_pkg::BLOCK_W-1:0]   mem2proc_data,
    output logic [1:0]                      proc2mem_command,
    output logic [fetch_pkg::XLEN-1:0]      proc2mem_addr,
    // backend stall levels
    input  logic                            rob_full,
    input  logic [3:0]                      rs_full,
    // branch resolution bus
    input  logic                            result_valid,
    input  logic                            result_cond_branch,
    input  logic                            result_uncond_branch,
    input  logic                            result_taken,
    input  logic                            result_mis_pred,
    input  logic [fetch_pkg::XLEN-1:0]      result_pc,
    input  logic [fetch_pkg::XLEN-1:0]      result_target_pc,
    // fetch packet to decode
    output logic                            id_valid,
    output logic                            id_pred_taken,
    output logic [fetch_pkg::XLEN-1:0]      id_pc,
    output logic [fetch_pkg::XLEN-1:0]      id_inst,
    output logic [fetch_pkg::XLEN-1:0]      id_pred_pc
);

    // fetch <-> icache
    logic [fetch_pkg::XLEN-1:0] icache_addr;
    logic [fetch_pkg::XLEN-1:0] icache_data;
    logic                       icache_valid;   // level, addressed block present

    //////////////////////////////////////////////////
    // fetch stage, holds the branch predictor
    //////////////////////////////////////////////////

    if_id_stage #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) if_id_stage_0 (
        .clock                (clock),
        .reset                (reset),
        .rob_full             (rob_full),
        .rs_full              (rs_full),
        .result_valid         (result_valid),
        .result_pc            (result_pc),
        .result_cond_branch   (result_cond_branch),
        .result_uncond_branch (result_uncond_branch),
        .result_taken         (result_taken),
        .result_target_pc     (result_target_pc),
        .result_mis_pred      (result_mis_pred),
        .icache_data          (icache_data),
        .icache_valid         (icache_valid),
        .icache_addr          (icache_addr),
        .id_valid             (id_valid),
        .id_pc                (id_pc),
        .id_inst              (id_inst),
        .id_pred_taken        (id_pred_taken),
        .id_pred_pc           (id_pred_pc)
    );

    //////////////////////////////////////////////////
    // instruction cache, sole memory requester
    //////////////////////////////////////////////////

    icache #(
        .ICACHE_LINES(ICACHE_LINES)
    ) icache_0 (
        .clock             (clock),
        .reset             (reset),
        .icache_addr       (icache_addr),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .mem2proc_data     (mem2proc_data),
        .icache_data       (icache_data),
        .icache_valid      (icache_valid),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr)
    );

endmodule

// ==== tests/processor_tb.sv ====
`timescale 1ns/1ns

module processor_tb;

    localparam logic [31:0] WORD_XOR = 32'hc0de_0013;   // inst word = address ^ this
    localparam int          WAIT_MAX = 200;              // cycles per wait loop

    logic        clock = 1'b0;
    logic        reset;
    logic [3:0]  mem2proc_response;
    logic [3:0]  mem2proc_tag;
    logic [63:0] mem2proc_data;
    logic [1:0]  proc2mem_command;
    logic [31:0] proc2mem_addr;
    logic        rob_full;
    logic [3:0]  rs_full;
    logic        result_valid;
    logic        result_cond_branch;
    logic        result_uncond_branch;
    logic        result_taken;
    logic        result_mis_pred;
    logic [31:0] result_pc;
    logic [31:0] result_target_pc;
    logic        id_valid;
    logic        id_pred_taken;
    logic [31:0] id_pc;
    logic [31:0] id_inst;
    logic [31:0] id_pred_pc;

    // memory model state for the one load in flight
    logic [7:0]  lfsr = 8'd9;
    logic        mem_busy = 1'b0;
    int          mem_wait;
    logic [3:0]  mem_tag;
    logic [31:0] mem_addr;
    logic [31:0] block_seen = '0;    // one bit per block below 0x100

    // expected fetch stream
    logic [31:0] exp_pc = '0;
    logic        pkt_seen;
    logic [31:0] pkt_pc;
    logic        bp_on = 1'b0;       // trained btb entry expected to predict taken
    logic [31:0] bp_pc;
    logic [31:0] bp_target;

    int errors = 0;
    int miss_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int load_count = 0;
    int pkt_count = 0;

    processor i_dut (.*);

    initial begin
        forever #20 clock = ~clock;
    end

    // stall or flush seen at an edge leaves no packet behind it
    assert property (@(posedge clock) disable iff (reset)
        (rob_full || rs_full != 4'b0000 || (result_valid && result_mis_pred)) |=> !id_valid)
    else begin
        errors++;
        $display("** Error at %0t ns: id_valid high after stall or redirect", $time);
    end

    assert property (@(posedge clock) disable iff (reset)
        proc2mem_command == fetch_pkg::BUS_LOAD |-> proc2mem_addr[2:0] == 3'b000)
    else begin
        errors++;
        miss_errors++;
        $display("** Error at %0t ns: load address %h not block aligned", $time, proc2mem_addr);
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ WORD_XOR;
    endfunction

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);   // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic take_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp)
        else begin
            errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string why);
        errors++;
        $display("timeout: %s", why);
    endtask

    task automatic report_test(input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, fails);
        end
    endtask

    //////////////////////////////////////////////////
    // one cycle of memory model and packet check
    //////////////////////////////////////////////////

    task automatic tick();
        int  v;
        logic predicted;
        @(negedge clock);
        mem2proc_response = '0;              // accept strobe lasts one cycle
        mem2proc_tag      = '0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem2proc_tag  = mem_tag;
                mem2proc_data = {mem_word(mem_addr + 32'd4), mem_word(mem_addr)};
                mem_busy      = 1'b0;
            end else begin
                mem_wait--;
            end
        end else if (proc2mem_command == fetch_pkg::BUS_LOAD) begin
            take_bits(3, v);
            mem_tag = 4'(v) + 4'd1;          // never zero
            take_bits(3, v);
            mem_wait = v % 6;                // data 1 to 6 cycles later
            mem_addr = proc2mem_addr;
            mem_busy = 1'b1;
            mem2proc_response = mem_tag;
            load_count++;
            assert (proc2mem_addr < 32'h100 && !block_seen[proc2mem_addr[7:3]])
            else begin
                errors++;
                miss_errors++;
                $display("** Error at %0t ns: block %h loaded twice or out of range",
                         $time, proc2mem_addr);
            end
            block_seen[proc2mem_addr[7:3]] = 1'b1;
        end
        pkt_seen = (id_valid === 1'b1);
        pkt_pc   = id_pc;
        if (pkt_seen) begin
            pkt_count++;
            predicted = bp_on && (exp_pc == bp_pc);
            check_value("id_pc", id_pc, exp_pc);
            check_value("id_inst", id_inst, mem_word(exp_pc));
            check_bit("id_pred_taken", id_pred_taken, predicted);
            if (predicted) begin
                check_value("id_pred_pc", id_pred_pc, bp_target);
                exp_pc = bp_target;
            end else begin
                check_value("id_pred_pc", id_pred_pc, exp_pc + 32'd4);
                exp_pc = exp_pc + 32'd4;
            end
        end
    endtask

    task automatic wait_for_pc(input logic [31:0] addr);
        int   n;
        logic found;
        n     = 0;
        found = 1'b0;
        while (!found && n < WAIT_MAX) begin
            tick();
            found = pkt_seen && (pkt_pc == addr);
            n++;
        end
        if (!found) note_timeout($sformatf("pc %h was never fetched", addr));
    endtask

    task automatic wait_packet();
        int n;
        n = 0;
        pkt_seen = 1'b0;
        while (!pkt_seen && n < WAIT_MAX) begin
            tick();
            n++;
        end
        if (!pkt_seen) note_timeout("no fetch packet after the stall was released");
    endtask

    task automatic hold_stall();
        tick();                              // first edge that sees the stall
        repeat (3) begin
            tick();
            check_bit("id_valid during stall", id_valid, 1'b0);
        end
    endtask

    // one result bus strobe
    task automatic send_result(input logic [31:0] pc, input logic [31:0] target,
                               input logic cond, input logic taken, input logic mis_pred);
        result_valid       = 1'b1;
        result_pc          = pc;
        result_target_pc   = target;
        result_cond_branch = cond;
        result_taken       = taken;
        result_mis_pred    = mis_pred;
        tick();
        result_valid       = 1'b0;
        result_cond_branch = 1'b0;
        result_mis_pred    = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial begin
        int err0;
        int loads_before;
        reset                = 1'b1;
        mem2proc_response    = '0;
        mem2proc_tag         = '0;
        mem2proc_data        = '0;
        rob_full             = 1'b0;
        rs_full              = '0;
        result_valid         = 1'b0;
        result_cond_branch   = 1'b0;
        result_uncond_branch = 1'b0;
        result_taken         = 1'b0;
        result_mis_pred      = 1'b0;
        result_pc            = '0;
        result_target_pc     = '0;
        tick();
        tick();                              // two rising edges in reset
        reset = 1'b0;

        err0 = errors;
        check_bit("id_valid after reset", id_valid, 1'b0);
        check_value("proc2mem_command after reset", 32'(proc2mem_command),
                    32'(fetch_pkg::BUS_NONE));
        report_test("reset", errors - err0);

        err0 = errors;
        wait_for_pc(32'h20);
        report_test("sequential fetch", errors - err0);

        err0 = errors;
        rs_full = 4'b0100;
        hold_stall();
        rs_full = 4'b0000;
        wait_packet();                       // continuity checked against exp_pc
        rob_full = 1'b1;
        hold_stall();
        rob_full = 1'b0;
        wait_packet();
        report_test("stall", errors - err0);

        err0 = errors;
        send_result(32'h0, 32'h60, 1'b0, 1'b1, 1'b1);
        exp_pc = 32'h60;
        wait_for_pc(32'h60);
        send_result(32'h10, 32'h0, 1'b0, 1'b0, 1'b1);   // not taken so fetch goes to pc+4
        exp_pc = 32'h14;
        wait_for_pc(32'h14);
        loads_before = load_count;
        wait_for_pc(32'h1c);                 // blocks 0x10, 0x18 already cached
        assert (load_count == loads_before)
        else begin
            errors++;
            miss_errors++;
            $display("** Error at %0t ns: reload after redirect into a cached block", $time);
        end
        report_test("redirect", errors - err0);

        // train pc 0x48 taken to 0x90 while fetch is held
        err0 = errors;
        rob_full = 1'b1;
        send_result(32'h48, 32'h90, 1'b1, 1'b1, 1'b0);
        send_result(32'h48, 32'h90, 1'b1, 1'b1, 1'b0);
        bp_on     = 1'b1;
        bp_pc     = 32'h48;
        bp_target = 32'h90;
        send_result(32'h0, 32'h40, 1'b0, 1'b1, 1'b1);
        exp_pc   = 32'h40;
        rob_full = 1'b0;
        wait_for_pc(32'h90);
        rob_full = 1'b1;
        send_result(32'h48, 32'h90, 1'b1, 1'b0, 1'b0);
        send_result(32'h48, 32'h90, 1'b1, 1'b0, 1'b0);
        bp_on = 1'b0;                        // counter back to weakly not taken
        send_result(32'h0, 32'h40, 1'b0, 1'b1, 1'b1);
        exp_pc   = 32'h40;
        rob_full = 1'b0;
        wait_for_pc(32'h4c);
        report_test("prediction training", errors - err0);

        report_test("miss traffic", miss_errors);

        $display("tests %0d, failed %0d, errors %0d, packets %0d, loads %0d",
                 tests_run, tests_failed, errors, pkt_count, load_count);
        if (errors == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== processor.f ====
common/fetch_pkg.sv
common/bp_if.sv
if_id_stage/branch_predictor.sv
if_id_stage/if_id_stage.sv
icache/icache.sv
verilog/processor.sv
tests/processor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module processor_tb \
    -f processor.f -o processor_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/processor_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Checks failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "All checks passed" sim.log && { echo "RESULT: PASS"; exit 0; }
echo "RESULT: FAIL, no result line in sim.log"
exit 1
